/* include/fpMul_settings.svh */
`default_nettype none

`ifndef FP_MUL_SETTINGS_SVH
`define FP_MUL_SETTINGS_SVH

// Single-precision field widths
`define FP_EXP_W   8
`define FP_FRAC_W  23

// Exponent bias and the all-ones exponent used by inf and NaN
`define FP_BIAS    127
`define FP_EXP_MAX 255

// Canonical quiet NaN returned for every NaN result
`define FP_QNAN    32'h7FC00000

`endif

`default_nettype wire

/* hw/fpMulPkg.sv */
`include "fpMul_settings.svh"
`default_nettype none

package fpMulPkg;

    // ==================================================
    // Operand and result format
    // ==================================================
    typedef struct packed {
        logic                  sign;
        logic [`FP_EXP_W-1:0]  exp;
        logic [`FP_FRAC_W-1:0] frac;
    } fpWord;

    // ==================================================
    // Rounding modes
    // ==================================================
    // Codes 5 to 7 fall back to RNE
    typedef enum logic [2:0] {
        RM_RNE = 3'd0,
        RM_RTZ = 3'd1,
        RM_RDN = 3'd2,
        RM_RUP = 3'd3,
        RM_RMM = 3'd4
    } roundMode;

    // Kind of result decided in stage 1
    typedef enum logic [1:0] {
        RES_NORMAL = 2'd0,
        RES_ZERO   = 2'd1,
        RES_INF    = 2'd2,
        RES_NAN    = 2'd3
    } resClass;

    // ==================================================
    // Control word carried from stage 1 to stage 3
    // ==================================================
    typedef struct packed {
        logic               sign;
        // Biased exponent of the product before normalization
        logic signed [9:0]  expSum;
        resClass            cls;
        roundMode           rMode;
    } mulCtl;

endpackage

`default_nettype wire

/* hw/fpUnpack.sv */
`include "fpMul_settings.svh"
`default_nettype none
`timescale 1ns/100ps

module fpUnpack import fpMulPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        inValid,
    input  fpWord       opA,
    input  fpWord       opB,
    input  roundMode    rMode,
    output logic        valid,
    output logic [23:0] mantA,
    output logic [23:0] mantB,
    output mulCtl       ctl
);

    logic  aZero, bZero;
    logic  aInf, bInf;
    logic  aNan, bNan;
    mulCtl ctlNext;

    // Exponent 0 covers both true zero and subnormals, which are flushed
    assign aZero = (opA.exp == '0);
    assign bZero = (opB.exp == '0);
    assign aInf  = (opA.exp == `FP_EXP_W'(`FP_EXP_MAX)) && (opA.frac == '0);
    assign bInf  = (opB.exp == `FP_EXP_W'(`FP_EXP_MAX)) && (opB.frac == '0);
    assign aNan  = (opA.exp == `FP_EXP_W'(`FP_EXP_MAX)) && (opA.frac != '0);
    assign bNan  = (opB.exp == `FP_EXP_W'(`FP_EXP_MAX)) && (opB.frac != '0);

    always_comb begin
        ctlNext.sign   = opA.sign ^ opB.sign;
        ctlNext.expSum = {2'b00, opA.exp} + {2'b00, opB.exp} - 10'(`FP_BIAS);
        ctlNext.rMode  = rMode;

        // Priority order is NaN, infinity, zero and then a normal product
        if (aNan || bNan || (aInf && bZero) || (bInf && aZero)) begin
            ctlNext.cls = RES_NAN;
        end else if (aInf || bInf) begin
            ctlNext.cls = RES_INF;
        end else if (aZero || bZero) begin
            ctlNext.cls = RES_ZERO;
        end else begin
            ctlNext.cls = RES_NORMAL;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else begin
            valid <= inValid;
        end
    end

    // Hidden bit restored and flushed operands give a zero mantissa
    always_ff @(posedge clk) begin
        mantA <= aZero ? 24'd0 : {1'b1, opA.frac};
        mantB <= bZero ? 24'd0 : {1'b1, opB.frac};
        ctl   <= ctlNext;
    end

endmodule

`default_nettype wire

/* hw/boothMul24.sv */
`default_nettype none
`timescale 1ns/100ps

module boothMul24 import fpMulPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        inValid,
    input  logic [23:0] mantA,
    input  logic [23:0] mantB,
    input  mulCtl       ctlIn,
    output logic        outValid,
    output logic [47:0] product,
    output mulCtl       ctlOut
);

    // ==================================================
    // Radix-4 digit recoding
    // ==================================================
    // Returns {neg, two, one} for one overlapping bit triplet
    function automatic logic [2:0] boothEncode(input logic [2:0] trip);
        logic [2:0] code;
        code[0] = trip[1] ^ trip[0];
        code[1] = (~trip[2] & trip[1] & trip[0]) | (trip[2] & ~trip[1] & ~trip[0]);
        code[2] = trip[2] & ~(trip[1] & trip[0]);
        return code;
    endfunction

    logic [24:0] multExt;
    logic [47:0] multiplicand;
    logic [47:0] partial;
    logic [47:0] accum;
    logic [2:0]  digit;

    assign multExt      = {mantB, 1'b0};
    assign multiplicand = {24'd0, mantA};

    // ==================================================
    // Partial products and their sum
    // ==================================================
    always_comb begin
        accum   = '0;
        partial = '0;
        digit   = '0;
        for (int i = 0; i < 12; i++) begin
            digit = boothEncode(multExt[2*i +: 3]);
            if (digit[1]) begin
                partial = multiplicand << 1;
            end else if (digit[0]) begin
                partial = multiplicand;
            end else begin
                partial = '0;
            end
            // Two's complement in 48 bits doubles as the sign extension
            if (digit[2]) begin
                partial = -partial;
            end
            accum = accum + (partial << (2 * i));
        end
        // Twelve digits read mantB as signed, so the hidden bit
        // costs one extra mantA at weight 2^24
        if (mantB[23]) begin
            accum = accum + (multiplicand << 24);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else begin
            outValid <= inValid;
        end
    end

    // Sideband stays aligned with the product
    always_ff @(posedge clk) begin
        product <= accum;
        ctlOut  <= ctlIn;
    end

endmodule

`default_nettype wire

/* hw/fpRoundPack.sv */
`include "fpMul_settings.svh"
`default_nettype none
`timescale 1ns/100ps

module fpRoundPack import fpMulPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        inValid,
    input  logic [47:0] product,
    input  mulCtl       ctl,
    output logic        outValid,
    output fpWord       result,
    output logic        ovrf,
    output logic        udrf
);

    logic [22:0]       fracRaw;
    logic              guard;
    logic              sticky;
    logic              roundUp;
    logic              toMaxFinite;
    logic [24:0]       sigRounded;
    logic signed [9:0] expNorm;
    logic signed [9:0] expFinal;
    logic              isNormal;
    logic              ovfNext;
    logic              udfNext;
    fpWord             resNext;

    // ==================================================
    // Normalize and round
    // ==================================================
    always_comb begin
        // Product of two 1.x values lies in [1, 4)
        if (product[47]) begin
            fracRaw = product[46:24];
            guard   = product[23];
            sticky  = |product[22:0];
        end else begin
            fracRaw = product[45:23];
            guard   = product[22];
            sticky  = |product[21:0];
        end
        expNorm = ctl.expSum + {9'd0, product[47]};

        case (ctl.rMode)
            RM_RTZ:  roundUp = 1'b0;
            RM_RDN:  roundUp = ctl.sign & (guard | sticky);
            RM_RUP:  roundUp = ~ctl.sign & (guard | sticky);
            RM_RMM:  roundUp = guard;
            default: roundUp = guard & (sticky | fracRaw[0]);
        endcase

        // Carry out of rounding leaves the fraction at zero
        sigRounded = {2'b01, fracRaw} + {24'd0, roundUp};
        expFinal   = expNorm + {9'd0, sigRounded[24]};
    end

    // Overflow saturates when rounding points toward zero
    always_comb begin
        case (ctl.rMode)
            RM_RTZ:  toMaxFinite = 1'b1;
            RM_RDN:  toMaxFinite = ~ctl.sign;
            RM_RUP:  toMaxFinite = ctl.sign;
            default: toMaxFinite = 1'b0;
        endcase
    end

    assign isNormal = (ctl.cls == RES_NORMAL);
    assign ovfNext  = isNormal && (expFinal >= 10'sd255);
    assign udfNext  = isNormal && (expFinal <= 10'sd0);

    // ==================================================
    // Result packing
    // ==================================================
    always_comb begin
        case (ctl.cls)
            RES_NAN: begin
                resNext = `FP_QNAN;
            end
            RES_INF: begin
                resNext = {ctl.sign, 8'(`FP_EXP_MAX), 23'd0};
            end
            RES_ZERO: begin
                resNext = {ctl.sign, 31'd0};
            end
            default: begin
                if (ovfNext) begin
                    resNext = toMaxFinite ? {ctl.sign, 8'(`FP_EXP_MAX - 1), 23'h7FFFFF}
                                          : {ctl.sign, 8'(`FP_EXP_MAX), 23'd0};
                end else if (udfNext) begin
                    resNext = {ctl.sign, 31'd0};
                end else begin
                    resNext = {ctl.sign, expFinal[7:0], sigRounded[22:0]};
                end
            end
        endcase
    end

    // Flags can only rise together with outValid
    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
            ovrf     <= 1'b0;
            udrf     <= 1'b0;
        end else begin
            outValid <= inValid;
            ovrf     <= inValid & ovfNext;
            udrf     <= inValid & udfNext;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            result <= resNext;
        end
    end

endmodule

`default_nettype wire

/* hw/fpMul.sv */
`default_nettype none
`timescale 1ns/100ps

module fpMul import fpMulPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     inValid,
    input  fpWord    opA,
    input  fpWord    opB,
    input  roundMode rMode,
    output logic     outValid,
    output fpWord    result,
    output logic     ovrf,
    output logic     udrf
);

    // Stage 1 outputs
    logic        unpValid;
    logic [23:0] unpMantA;
    logic [23:0] unpMantB;
    mulCtl       unpCtl;

    // Stage 2 outputs
    logic        mulValid;
    logic [47:0] mulProduct;
    mulCtl       mulCtlOut;

    // ==================================================
    // Three-stage pipeline with one cycle per stage
    // ==================================================
    fpUnpack u_unpack (
        .clk     (clk),
        .rst     (rst),
        .inValid (inValid),
        .opA     (opA),
        .opB     (opB),
        .rMode   (rMode),
        .valid   (unpValid),
        .mantA   (unpMantA),
        .mantB   (unpMantB),
        .ctl     (unpCtl)
    );

    boothMul24 u_booth (
        .clk      (clk),
        .rst      (rst),
        .inValid  (unpValid),
        .mantA    (unpMantA),
        .mantB    (unpMantB),
        .ctlIn    (unpCtl),
        .outValid (mulValid),
        .product  (mulProduct),
        .ctlOut   (mulCtlOut)
    );

    fpRoundPack u_round (
        .clk      (clk),
        .rst      (rst),
        .inValid  (mulValid),
        .product  (mulProduct),
        .ctl      (mulCtlOut),
        .outValid (outValid),
        .result   (result),
        .ovrf     (ovrf),
        .udrf     (udrf)
    );

endmodule

`default_nettype wire

/* verif/fpMul_checker.sv */
`include "fpMul_settings.svh"
`default_nettype none
`timescale 1ns/100ps

module fpMulChecker import fpMulPkg::*; (
    input wire logic        clk,
    input wire logic        rst,
    input wire logic        inValid,
    input wire fpWord       opA,
    input wire fpWord       opB,
    input wire logic        outValid,
    input wire fpWord       result,
    input wire logic        ovrf,
    input wire logic        udrf,
    input wire logic        mantValid,
    input wire logic [23:0] mantA,
    input wire logic [23:0] mantB,
    input wire logic [47:0] product
);

    logic zeroCase;
    logic zeroSign;

    // Flushed operand against anything but inf or NaN
    assign zeroCase = inValid &&
        (((opA.exp == 8'd0) && (opB.exp != 8'(`FP_EXP_MAX))) ||
         ((opB.exp == 8'd0) && (opA.exp != 8'(`FP_EXP_MAX))));
    assign zeroSign = opA.sign ^ opB.sign;

    // ==================================================
    // Pipeline properties
    // ==================================================
    boothProduct: assert property (@(posedge clk) disable iff (rst)
        $past(mantValid) |-> (product == 48'($past(mantA)) * 48'($past(mantB))))
        else $error("Booth product differs from the plain mantissa product");

    zeroResult: assert property (@(posedge clk) disable iff (rst)
        $past(zeroCase, 3) |-> (outValid && (result == {$past(zeroSign, 3), 31'd0})))
        else $error("Zero operand did not give a signed zero after three cycles");

    validAfterReset: assert property (@(posedge clk)
        $past(rst) |-> !outValid)
        else $error("outValid high in the cycle after reset");

    flagsNeedValid: assert property (@(posedge clk)
        (ovrf || udrf) |-> outValid)
        else $error("Overflow or underflow flag high without outValid");

endmodule

bind fpMul fpMulChecker u_checker (
    .clk       (clk),
    .rst       (rst),
    .inValid   (inValid),
    .opA       (opA),
    .opB       (opB),
    .outValid  (outValid),
    .result    (result),
    .ovrf      (ovrf),
    .udrf      (udrf),
    .mantValid (unpValid),
    .mantA     (unpMantA),
    .mantB     (unpMantB),
    .product   (mulProduct)
);

`default_nettype wire

/* verif/fpMulTb.sv */
`include "fpMul_settings.svh"
`default_nettype none
`timescale 1ns/100ps

module fpMulTb import fpMulPkg::*; ();

    localparam int TIMEOUT_CYCLES = 20;
    localparam int STREAM_LEN     = 200;
    // Cycles from the edge that samples inValid to a visible result
    localparam int LATENCY        = 3;

    // Operand pairs {opA, opB} with guard or sticky bits set
    localparam logic [63:0] ROUND_CASES [6] = '{
        64'h3F800001_3FC00000,  // tie with odd fraction
        64'h3F800003_3FC00000,  // tie with even fraction
        64'h3FFFFFF8_3F800008,  // 1.999999 x 1.000001
        64'h3FB504F3_3FB504F3,  // sqrt2 squared gives a rounding carry
        64'h3DCCCCCD_3DCCCCCD,
        64'hBF9D70A4_40490FDB
    };

    // First three overflow and last three underflow
    localparam logic [63:0] RANGE_CASES [6] = '{
        64'h7F000000_40000000,
        64'hFF000000_40000000,
        64'h7F7FFFFF_FF7FFFFF,
        64'h00800000_3F000000,
        64'h80800000_3F000000,
        64'h0DA24260_0DA24260
    };

    // {opA, opB, expected result}
    localparam logic [95:0] SPECIAL_CASES [11] = '{
        96'h00000000_C0400000_80000000,
        96'h80000000_3F800000_80000000,
        96'h00000001_3F800000_00000000,
        96'h807FFFFF_BF800000_00000000,
        96'h7F800000_C0000000_FF800000,
        96'hFF800000_FF7FFFFF_7F800000,
        96'h7F800000_00000000_7FC00000,
        96'h80000000_FF800000_7FC00000,
        96'h7FC00001_3F800000_7FC00000,
        96'hFFFFFFFF_00000000_7FC00000,
        96'h7F800001_7F800000_7FC00000
    };

    typedef struct packed {
        fpWord res;
        logic  ovrf;
        logic  udrf;
    } mulResult;

    logic     clk;
    logic     rst;
    logic     inValid;
    fpWord    opA;
    fpWord    opB;
    roundMode rMode;
    logic     outValid;
    fpWord    result;
    logic     ovrf;
    logic     udrf;
    integer   seed;

    fpMul u_fpMul (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .opA      (opA),
        .opB      (opB),
        .rMode    (rMode),
        .outValid (outValid),
        .result   (result),
        .ovrf     (ovrf),
        .udrf     (udrf)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ==================================================
    // Reference model and compare tasks
    // ==================================================
    function automatic mulResult refMul(input fpWord a, input fpWord b, input roundMode m);
        mulResult    r;
        logic        aZero, bZero, aInf, bInf, aNan, bNan;
        logic        sgn, grd, stk, up, toMax;
        logic [47:0] prod;
        logic [23:0] sig;
        logic [24:0] sum;
        int          e;
        r     = '0;
        sgn   = a.sign ^ b.sign;
        aZero = (a.exp == 8'd0);
        bZero = (b.exp == 8'd0);
        aInf  = (a.exp == 8'(`FP_EXP_MAX)) && (a.frac == 23'd0);
        bInf  = (b.exp == 8'(`FP_EXP_MAX)) && (b.frac == 23'd0);
        aNan  = (a.exp == 8'(`FP_EXP_MAX)) && (a.frac != 23'd0);
        bNan  = (b.exp == 8'(`FP_EXP_MAX)) && (b.frac != 23'd0);
        if (aNan || bNan || (aInf && bZero) || (bInf && aZero)) begin
            r.res = `FP_QNAN;
        end else if (aInf || bInf) begin
            r.res = {sgn, 8'(`FP_EXP_MAX), 23'd0};
        end else if (aZero || bZero) begin
            r.res = {sgn, 31'd0};
        end else begin
            prod = {24'd0, 1'b1, a.frac} * {24'd0, 1'b1, b.frac};
            e    = int'(a.exp) + int'(b.exp) - `FP_BIAS;
            if (prod[47]) begin
                sig = prod[47:24];
                grd = prod[23];
                stk = |prod[22:0];
                e   = e + 1;
            end else begin
                sig = prod[46:23];
                grd = prod[22];
                stk = |prod[21:0];
            end
            case (m)
                RM_RTZ:  up = 1'b0;
                RM_RDN:  up = sgn && (grd || stk);
                RM_RUP:  up = !sgn && (grd || stk);
                RM_RMM:  up = grd;
                default: up = grd && (stk || sig[0]);
            endcase
            sum = {1'b0, sig} + 25'(up);
            if (sum[24]) begin
                e   = e + 1;
                sum = sum >> 1;
            end
            toMax = (m == RM_RTZ) || ((m == RM_RDN) && !sgn) || ((m == RM_RUP) && sgn);
            if (e >= `FP_EXP_MAX) begin
                r.ovrf = 1'b1;
                r.res  = toMax ? {sgn, 8'(`FP_EXP_MAX - 1), 23'h7FFFFF}
                               : {sgn, 8'(`FP_EXP_MAX), 23'd0};
            end else if (e <= 0) begin
                r.udrf = 1'b1;
                r.res  = {sgn, 31'd0};
            end else begin
                r.res = {sgn, 8'(e), sum[22:0]};
            end
        end
        return r;
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic checkWord(input string testName, input fpWord expected, input fpWord actual);
        if (actual !== expected) begin
            abortRun($sformatf("ERR %s: expected %h, actual %h", testName, expected, actual));
        end
    endtask

    task automatic checkFlag(input string testName, input string flagName,
                             input logic expected, input logic actual);
        if (actual !== expected) begin
            abortRun($sformatf("ERR %s %s: expected %b, actual %b",
                               testName, flagName, expected, actual));
        end
    endtask

    task automatic checkLatency(input string testName, input int expected, input int actual);
        if (actual != expected) begin
            abortRun($sformatf("ERR %s latency: expected %0d, actual %0d",
                               testName, expected, actual));
        end
    endtask

    // Called on a falling edge and returns on the falling edge that shows outValid
    task automatic runOp(input string testName, input fpWord a, input fpWord b,
                         input roundMode m, output mulResult got);
        int waitCycles;
        opA     = a;
        opB     = b;
        rMode   = m;
        inValid = 1'b1;
        @(negedge clk);
        inValid    = 1'b0;
        waitCycles = 1;
        while (!outValid) begin
            if (waitCycles == TIMEOUT_CYCLES) begin
                abortRun("Timeout: no result arrived for an accepted operation");
            end else begin
                @(negedge clk);
                waitCycles++;
            end
        end
        checkLatency(testName, LATENCY, waitCycles);
        got = {result, ovrf, udrf};
    endtask

    task automatic checkOp(input string testName, input fpWord a, input fpWord b,
                           input roundMode m, input mulResult expected);
        mulResult got;
        runOp(testName, a, b, m, got);
        checkWord(testName, expected.res, got.res);
        checkFlag(testName, "ovrf", expected.ovrf, got.ovrf);
        checkFlag(testName, "udrf", expected.udrf, got.udrf);
    endtask

    function automatic fpWord randomNormal();
        fpWord w;
        w.sign = 1'($random(seed));
        w.exp  = 8'(97 + ($random(seed) & 63));
        w.frac = 23'($random(seed));
        return w;
    endfunction

    // ==================================================
    // Directed tests
    // ==================================================
    task automatic testExact();
        roundMode m;
        for (int k = 0; k < 5; k++) begin
            m = roundMode'(3'(k));
            checkOp($sformatf("exact 1.5*2.0 %s", m.name()),
                    32'h3FC00000, 32'h40000000, m, {32'h40400000, 2'b00});
            checkOp($sformatf("exact -3.0*0.5 %s", m.name()),
                    32'hC0400000, 32'h3F000000, m, {32'hBFC00000, 2'b00});
            checkOp($sformatf("exact 1.25*1.25 %s", m.name()),
                    32'h3FA00000, 32'h3FA00000, m, {32'h3FC80000, 2'b00});
        end
    endtask

    task automatic testRounding();
        roundMode m;
        fpWord    a;
        fpWord    b;
        for (int i = 0; i < 6; i++) begin
            a = ROUND_CASES[i][63:32];
            b = ROUND_CASES[i][31:0];
            for (int k = 0; k < 5; k++) begin
                m = roundMode'(3'(k));
                checkOp($sformatf("round case %0d %s", i, m.name()), a, b, m, refMul(a, b, m));
            end
        end
    endtask

    task automatic testRange();
        roundMode m;
        fpWord    a;
        fpWord    b;
        mulResult got;
        string    name;
        for (int i = 0; i < 6; i++) begin
            a = RANGE_CASES[i][63:32];
            b = RANGE_CASES[i][31:0];
            for (int k = 0; k < 5; k++) begin
                m    = roundMode'(3'(k));
                name = $sformatf("range case %0d %s", i, m.name());
                runOp(name, a, b, m, got);
                checkFlag(name, "ovrf", i < 3, got.ovrf);
                checkFlag(name, "udrf", i >= 3, got.udrf);
                checkWord(name, refMul(a, b, m).res, got.res);
            end
        end
    endtask

    task automatic testSpecials();
        roundMode m;
        for (int i = 0; i < 11; i++) begin
            m = roundMode'(3'(i % 5));
            checkOp($sformatf("special case %0d", i), SPECIAL_CASES[i][95:64],
                    SPECIAL_CASES[i][63:32], m, {SPECIAL_CASES[i][31:0], 2'b00});
        end
    endtask

    // Operands on every cycle and results compared in arrival order
    task automatic testStream();
        fpWord    streamA [STREAM_LEN];
        fpWord    streamB [STREAM_LEN];
        roundMode streamM [STREAM_LEN];
        mulResult expQ [$];
        mulResult expected;
        int       received;
        int       idle;
        for (int i = 0; i < STREAM_LEN; i++) begin
            streamA[i] = randomNormal();
            streamB[i] = randomNormal();
            streamM[i] = roundMode'(3'(($random(seed) & 32'h7FFFFFFF) % 5));
            expQ.push_back(refMul(streamA[i], streamB[i], streamM[i]));
        end
        fork
            begin
                for (int i = 0; i < STREAM_LEN; i++) begin
                    opA     = streamA[i];
                    opB     = streamB[i];
                    rMode   = streamM[i];
                    inValid = 1'b1;
                    @(negedge clk);
                end
                inValid = 1'b0;
            end
            begin
                received = 0;
                idle     = 0;
                while (received < STREAM_LEN) begin
                    @(negedge clk);
                    if (outValid) begin
                        expected = expQ.pop_front();
                        checkWord($sformatf("stream %0d", received), expected.res, result);
                        checkFlag($sformatf("stream %0d", received), "ovrf", expected.ovrf, ovrf);
                        checkFlag($sformatf("stream %0d", received), "udrf", expected.udrf, udrf);
                        received++;
                        idle = 0;
                    end else if (idle == TIMEOUT_CYCLES) begin
                        abortRun("Timeout: stream results stopped arriving");
                    end else begin
                        idle++;
                    end
                end
            end
        join
    endtask

    initial begin
        seed    = 47;
        rst     = 1'b1;
        inValid = 1'b0;
        opA     = '0;
        opB     = '0;
        rMode   = RM_RNE;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        testExact();
        testRounding();
        testRange();
        testSpecials();
        testStream();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* fpMul.f */
+incdir+include
hw/fpMulPkg.sv
hw/fpUnpack.sv
hw/boothMul24.sv
hw/fpRoundPack.sv
hw/fpMul.sv
verif/fpMul_checker.sv
verif/fpMulTb.sv

/* Makefile */
TOP := fpMulTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f fpMul.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f fpMul.f --top-module $(TOP) -Mdir obj_dir
	-./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "SIMULATION FAILED" sim.log || ! grep -q "SIMULATION PASSED" sim.log; then \
		echo "simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
